// File: vlog.f
rtl/vinsn_pkg.sv
rtl/lane_bus_pkg.sv
rtl/bus_order_ctrl.sv
rtl/bus_steer.sv
rtl/mask_spill_register.sv
rtl/lane_bus_arbiter.sv
bench/tb_lane_bus_arbiter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the lane bus arbiter testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_lane_bus_arbiter \
  --Mdir "$build_dir" \
  -f vlog.f
if [ $? -ne 0 ]; then
  echo "Compilation failed"
  exit 1
fi

"./$build_dir/Vtb_lane_bus_arbiter" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TEST PASS$" "$log_file"; then
  exit 0
fi
echo "Pass line not found in $log_file"
exit 1

// File: bench/tb_lane_bus_arbiter.sv
`timescale 1ns/1ns

module tb_lane_bus_arbiter;

  import vinsn_pkg::*;
  import lane_bus_pkg::*;

  localparam int unsigned elen_width  = default_elen_width;
  localparam int unsigned order_depth = default_order_depth;
  localparam int unsigned mask_width  = elen_width / 8;
  localparam int unsigned mask_words  = 40;
  localparam int unsigned wait_limit  = 16;

  logic                  clk_i = 1'b0;
  logic                  arst_n_i;
  logic                  flush_i;
  logic                  vfu_op_valid_i;
  vop_e                  vfu_op_i;
  logic                  slide_cmd_pop_i;
  logic                  alu_red_complete_i;
  logic                  fpu_red_complete_i;
  logic [elen_width-1:0] opq_data_i;
  logic                  opq_valid_i;
  logic                  opq_ready_o;
  logic [elen_width-1:0] alu_red_data_i;
  logic                  alu_red_valid_i;
  logic                  alu_red_gnt_o;
  logic [elen_width-1:0] fpu_red_data_i;
  logic                  fpu_red_valid_i;
  logic                  fpu_red_gnt_o;
  logic [elen_width-1:0] shared_operand_o;
  logic                  sldu_operand_valid_o;
  logic                  sldu_operand_ready_i;
  logic                  addrgen_operand_valid_o;
  logic                  addrgen_operand_ready_i;
  logic                  sldu_red_valid_i;
  logic                  alu_red_in_valid_o;
  logic                  fpu_red_in_valid_o;
  logic                  alu_red_in_ready_i;
  logic                  fpu_red_in_ready_i;
  logic                  sldu_result_gnt_opq_i;
  logic                  sldu_result_gnt_o;
  logic [mask_width-1:0] mask_i;
  logic                  mask_valid_i;
  logic                  mask_ready_o;
  logic [mask_width-1:0] mask_o;
  logic                  mask_valid_o;
  logic                  mask_ready_i;

  // Reference model of the owner record and the mask register
  bus_owner_e            owner_q[$];
  bus_owner_e            exp_owner    = owner_slide;
  logic                  op_valid_d   = 1'b0;
  vop_e                  op_d         = vop_vadd;
  logic [mask_width-1:0] mask_ref[$];
  logic [mask_width-1:0] mask_head    = '0;
  logic [mask_width-1:0] mask_in_word = '0;
  logic                  in_hs        = 1'b0;
  logic                  out_hs       = 1'b0;
  logic                  mask_seen    = 1'b0;
  int unsigned           mask_pending = 0;
  int unsigned           mask_rcvd    = 0;

  logic [31:0] lfsr_state      = 32'h55f57aaa;
  string       test_name       = "reset";
  int          errors          = 0;
  int          errors_at_start = 0;
  int          tests_run       = 0;
  logic        hung            = 1'b0;
  logic        streams_valid   = 1'b0;

  logic [elen_width-1:0] exp_shared;
  logic                  exp_sldu_valid;
  logic                  exp_addrgen_valid;
  logic [2:0]            exp_src_ready;
  logic [1:0]            exp_ret_valid;
  logic                  exp_result_gnt;

  always #5 clk_i = ~clk_i;

  lane_bus_arbiter #(
    .elen_width (elen_width ),
    .order_depth(order_depth)
  ) dut (.*);

  ////////////////////////////////////////
  // Expected routing for the model owner
  ////////////////////////////////////////

  assign exp_shared = (exp_owner == owner_alu_red) ? alu_red_data_i :
                      (exp_owner == owner_fpu_red) ? fpu_red_data_i : opq_data_i;
  assign exp_sldu_valid = (exp_owner == owner_alu_red) ? alu_red_valid_i :
                          (exp_owner == owner_fpu_red) ? fpu_red_valid_i :
                          (exp_owner == owner_slide)   ? opq_valid_i : 1'b0;
  assign exp_addrgen_valid = (exp_owner == owner_addrgen) & opq_valid_i;
  assign exp_src_ready[2] = (exp_owner == owner_slide)   ? sldu_operand_ready_i :
                            (exp_owner == owner_addrgen) ? addrgen_operand_ready_i : 1'b0;
  assign exp_src_ready[1] = (exp_owner == owner_alu_red) & sldu_operand_ready_i;
  assign exp_src_ready[0] = (exp_owner == owner_fpu_red) & sldu_operand_ready_i;
  assign exp_ret_valid[1] = (exp_owner == owner_alu_red) & sldu_red_valid_i;
  assign exp_ret_valid[0] = (exp_owner == owner_fpu_red) & sldu_red_valid_i;
  assign exp_result_gnt = (exp_owner == owner_alu_red) ? alu_red_in_ready_i :
                          (exp_owner == owner_fpu_red) ? fpu_red_in_ready_i :
                                                         sldu_result_gnt_opq_i;

  function automatic logic uses_bus(input vop_e op);
    return (op == vop_vslideup) || (op == vop_vslidedown) ||
           (op == vop_vlxe) || (op == vop_vsxe) ||
           (op >= vop_vredsum && op <= vop_vwredsum) ||
           (op >= vop_vfredusum && op <= vop_vfwredosum);
  endfunction

  function automatic bus_owner_e owner_for(input vop_e op);
    if (op == vop_vlxe || op == vop_vsxe) begin
      return owner_addrgen;
    end else if (op >= vop_vredsum && op <= vop_vwredsum) begin
      return owner_alu_red;
    end else if (op >= vop_vfredusum && op <= vop_vfwredosum) begin
      return owner_fpu_red;
    end
    return owner_slide;
  endfunction

  function automatic logic head_retires(input bus_owner_e own);
    case (own)
      owner_alu_red: return alu_red_complete_i;
      owner_fpu_red: return fpu_red_complete_i;
      default:       return slide_cmd_pop_i;
    endcase
  endfunction

  // Handshakes are taken mid-cycle, where the outputs are settled
  always @(negedge clk_i) begin
    in_hs        = mask_valid_i & mask_ready_o;
    out_hs       = mask_valid_o & mask_ready_i;
    mask_in_word = mask_i;
  end

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      owner_q.delete();
      mask_ref.delete();
      op_valid_d = 1'b0;
      mask_seen  = 1'b0;
      mask_rcvd  = 0;
    end else begin
      if (flush_i) begin
        owner_q.delete();
      end else begin
        if (op_valid_d && uses_bus(op_d) && owner_q.size() < order_depth) begin
          if (owner_q.size() != 0 && head_retires(owner_q[0])) begin
            void'(owner_q.pop_front());
          end
          owner_q.push_back(owner_for(op_d));
        end else if (owner_q.size() != 0 && head_retires(owner_q[0])) begin
          void'(owner_q.pop_front());
        end
      end
      op_valid_d = vfu_op_valid_i;
      op_d       = vfu_op_i;
      // Every output handshake counts, so a duplicated word shows up
      if (out_hs) begin
        if (mask_ref.size() != 0) begin
          void'(mask_ref.pop_front());
        end
        mask_rcvd++;
      end
      if (in_hs) begin
        mask_ref.push_back(mask_in_word);
        mask_seen = 1'b1;
      end
    end
    exp_owner    = (owner_q.size() == 0) ? owner_slide : owner_q[0];
    mask_pending = mask_ref.size();
    mask_head    = (mask_ref.size() == 0) ? '0 : mask_ref[0];
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_shared: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    shared_operand_o == exp_shared)
    else report_mismatch("shared_operand_o", exp_shared, shared_operand_o);

  a_consumer_valid: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    {sldu_operand_valid_o, addrgen_operand_valid_o} == {exp_sldu_valid, exp_addrgen_valid})
    else report_mismatch("sldu/addrgen valid", 64'({exp_sldu_valid, exp_addrgen_valid}),
                         64'({sldu_operand_valid_o, addrgen_operand_valid_o}));

  a_source_ready: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    {opq_ready_o, alu_red_gnt_o, fpu_red_gnt_o} == exp_src_ready)
    else report_mismatch("opq/alu/fpu ready", 64'(exp_src_ready),
                         64'({opq_ready_o, alu_red_gnt_o, fpu_red_gnt_o}));

  a_return_valid: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    {alu_red_in_valid_o, fpu_red_in_valid_o} == exp_ret_valid)
    else report_mismatch("alu/fpu return valid", 64'(exp_ret_valid),
                         64'({alu_red_in_valid_o, fpu_red_in_valid_o}));

  a_result_gnt: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    sldu_result_gnt_o == exp_result_gnt)
    else report_mismatch("sldu_result_gnt_o", 64'(exp_result_gnt), 64'(sldu_result_gnt_o));

  a_mask_data: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    !(mask_valid_o && mask_ready_i) || (mask_o == mask_head))
    else report_mismatch("mask_o", 64'(mask_head), 64'(mask_o));

  a_mask_valid: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    mask_valid_o == (mask_pending != 0))
    else report_mismatch("mask_valid_o", 64'(mask_pending != 0), 64'(mask_valid_o));

  a_mask_ready: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    mask_ready_o == (mask_pending < 2))
    else report_mismatch("mask_ready_o", 64'(mask_pending < 2), 64'(mask_ready_o));

  a_mask_idle: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    mask_seen || !mask_valid_o)
    else report_mismatch("mask_valid_o before first word", 64'(0), 64'(mask_valid_o));

  task automatic report_mismatch(input string what, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    errors++;
    $display("[FAIL] %s: %s expected %0h actual %0h", test_name, what, exp_val, act_val);
  endtask

  task automatic report_timeout(input string what);
    errors++;
    hung = 1'b1;
    $display("%s: gave up waiting for %s", test_name, what);
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic rand_bit();
    logic fb;
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      val = {val[62:0], rand_bit()};
    end
    return val;
  endfunction

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  // Tagged upper byte keeps the three sources distinct
  task automatic drive_streams();
    logic [63:0] r;
    r                       = rand_bits(56);
    opq_data_i              = {8'h01, r[55:0]};
    r                       = rand_bits(56);
    alu_red_data_i          = {8'h02, r[55:0]};
    r                       = rand_bits(56);
    fpu_red_data_i          = {8'h03, r[55:0]};
    opq_valid_i             = streams_valid | rand_bit();
    alu_red_valid_i         = streams_valid | rand_bit();
    fpu_red_valid_i         = streams_valid | rand_bit();
    sldu_operand_ready_i    = rand_bit();
    addrgen_operand_ready_i = rand_bit();
    sldu_red_valid_i        = rand_bit();
    alu_red_in_ready_i      = rand_bit();
    fpu_red_in_ready_i      = rand_bit();
    sldu_result_gnt_opq_i   = rand_bit();
  endtask

  task automatic run_cycles(input int unsigned n, input logic strobes);
    repeat (n) begin
      drive_streams();
      if (strobes) begin
        slide_cmd_pop_i    = rand_bit();
        alu_red_complete_i = rand_bit();
        fpu_red_complete_i = rand_bit();
      end
      step();
    end
    slide_cmd_pop_i    = 1'b0;
    alu_red_complete_i = 1'b0;
    fpu_red_complete_i = 1'b0;
  endtask

  task automatic issue_op(input vop_e op);
    vfu_op_valid_i = 1'b1;
    vfu_op_i       = op;
    drive_streams();
    step();
    vfu_op_valid_i = 1'b0;
  endtask

  task automatic wait_record(input int want);
    int unsigned tries;
    tries = 0;
    while (owner_q.size() != want && tries < wait_limit) begin
      drive_streams();
      step();
      tries++;
    end
    if (owner_q.size() != want) begin
      report_timeout("the owner record to settle");
    end
  endtask

  // Pulses the completion strobe that belongs to the head owner
  task automatic retire_head();
    int          n_before;
    int unsigned tries;
    n_before = owner_q.size();
    tries    = 0;
    while (owner_q.size() == n_before && tries < wait_limit) begin
      slide_cmd_pop_i    = (exp_owner == owner_slide) || (exp_owner == owner_addrgen);
      alu_red_complete_i = (exp_owner == owner_alu_red);
      fpu_red_complete_i = (exp_owner == owner_fpu_red);
      drive_streams();
      step();
      tries++;
    end
    slide_cmd_pop_i    = 1'b0;
    alu_red_complete_i = 1'b0;
    fpu_red_complete_i = 1'b0;
    if (owner_q.size() == n_before) begin
      report_timeout("the head owner to retire");
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic check_order();
    issue_op(vop_vslideup);
    issue_op(vop_vlxe);
    issue_op(vop_vredsum);
    issue_op(vop_vfredusum);
    wait_record(4);
    run_cycles(3, 1'b0);
    repeat (4) begin
      retire_head();
      run_cycles(3, 1'b0);
    end
  endtask

  task automatic check_non_bus();
    issue_op(vop_vadd);
    run_cycles(10, 1'b1);
  endtask

  task automatic check_return_path();
    issue_op(vop_vfredosum);
    issue_op(vop_vslidedown);
    issue_op(vop_vredxor);
    issue_op(vop_vsxe);
    wait_record(4);
    repeat (4) begin
      run_cycles(6, 1'b0);
      retire_head();
    end
  endtask

  task automatic check_flush();
    issue_op(vop_vredsum);
    issue_op(vop_vredand);
    issue_op(vop_vfredmin);
    wait_record(3);
    run_cycles(2, 1'b0);
    flush_i = 1'b1;
    step();
    flush_i = 1'b0;
    run_cycles(3, 1'b0);
    // Flush lands on the cycle the issued code would be pushed
    issue_op(vop_vfredosum);
    flush_i = 1'b1;
    step();
    flush_i = 1'b0;
    run_cycles(4, 1'b0);
  endtask

  task automatic check_mask_spill();
    logic [63:0] r;
    logic        accepted;
    int unsigned sent;
    int unsigned cycles;
    sent   = 0;
    cycles = 0;
    while (mask_rcvd < mask_words && cycles < mask_words * 20) begin
      if (!mask_valid_i && sent < mask_words && (rand_bit() | rand_bit())) begin
        r            = rand_bits(mask_width);
        mask_i       = r[mask_width-1:0];
        mask_valid_i = 1'b1;
      end
      mask_ready_i = rand_bit() | rand_bit();
      @(negedge clk_i);
      accepted = mask_valid_i & mask_ready_o;
      step();
      if (accepted) begin
        sent++;
        mask_valid_i = 1'b0;
      end
      cycles++;
    end
    mask_ready_i = 1'b0;
    if (mask_rcvd < mask_words) begin
      report_timeout("all mask words to leave the spill register");
    end
    a_mask_count: assert (mask_rcvd == sent)
      else report_mismatch("mask words received", 64'(sent), 64'(mask_rcvd));
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    $display("[DONE] %s: %0d failures", test_name, errors - errors_at_start);
  endtask

  initial begin
    arst_n_i                = 1'b0;
    flush_i                 = 1'b0;
    vfu_op_valid_i          = 1'b0;
    vfu_op_i                = vop_vadd;
    slide_cmd_pop_i         = 1'b0;
    alu_red_complete_i      = 1'b0;
    fpu_red_complete_i      = 1'b0;
    opq_data_i              = '0;
    opq_valid_i             = 1'b0;
    alu_red_data_i          = '0;
    alu_red_valid_i         = 1'b0;
    fpu_red_data_i          = '0;
    fpu_red_valid_i         = 1'b0;
    sldu_operand_ready_i    = 1'b0;
    addrgen_operand_ready_i = 1'b0;
    sldu_red_valid_i        = 1'b0;
    alu_red_in_ready_i      = 1'b0;
    fpu_red_in_ready_i      = 1'b0;
    sldu_result_gnt_opq_i   = 1'b0;
    mask_i                  = '0;
    mask_valid_i            = 1'b0;
    mask_ready_i            = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    step();

    begin_test("order");
    streams_valid = 1'b1;
    check_order();
    end_test();
    begin_test("non_bus");
    streams_valid = 1'b0;
    if (!hung) check_non_bus();
    end_test();
    begin_test("return_path");
    if (!hung) check_return_path();
    end_test();
    begin_test("flush");
    if (!hung) check_flush();
    end_test();
    begin_test("mask_spill");
    if (!hung) check_mask_spill();
    end_test();

    $display("%0d tests run, %0d checks failed", tests_run, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: rtl/lane_bus_arbiter.sv
`timescale 1ns/1ns

module lane_bus_arbiter #(
  parameter int unsigned elen_width  = lane_bus_pkg::default_elen_width,
  parameter int unsigned order_depth = lane_bus_pkg::default_order_depth
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    flush_i,
  // Issue and completion
  input  logic                    vfu_op_valid_i,
  input  vinsn_pkg::vop_e         vfu_op_i,
  input  logic                    slide_cmd_pop_i,
  input  logic                    alu_red_complete_i,
  input  logic                    fpu_red_complete_i,
  // Stream sources
  input  logic [elen_width-1:0]   opq_data_i,
  input  logic                    opq_valid_i,
  output logic                    opq_ready_o,
  input  logic [elen_width-1:0]   alu_red_data_i,
  input  logic                    alu_red_valid_i,
  output logic                    alu_red_gnt_o,
  input  logic [elen_width-1:0]   fpu_red_data_i,
  input  logic                    fpu_red_valid_i,
  output logic                    fpu_red_gnt_o,
  // Shared bus to slide unit and address generator
  output logic [elen_width-1:0]   shared_operand_o,
  output logic                    sldu_operand_valid_o,
  input  logic                    sldu_operand_ready_i,
  output logic                    addrgen_operand_valid_o,
  input  logic                    addrgen_operand_ready_i,
  // Reduction return path
  input  logic                    sldu_red_valid_i,
  output logic                    alu_red_in_valid_o,
  output logic                    fpu_red_in_valid_o,
  input  logic                    alu_red_in_ready_i,
  input  logic                    fpu_red_in_ready_i,
  input  logic                    sldu_result_gnt_opq_i,
  output logic                    sldu_result_gnt_o,
  // Mask stream
  input  logic [elen_width/8-1:0] mask_i,
  input  logic                    mask_valid_i,
  output logic                    mask_ready_o,
  output logic [elen_width/8-1:0] mask_o,
  output logic                    mask_valid_o,
  input  logic                    mask_ready_i
);

  import lane_bus_pkg::*;

  bus_owner_e owner;

  ////////////////////////////////////////
  // Bus order
  ////////////////////////////////////////

  bus_order_ctrl #(
    .order_depth(order_depth)
  ) i_bus_order_ctrl (
    .clk_i             (clk_i             ),
    .arst_n_i          (arst_n_i          ),
    .flush_i           (flush_i           ),
    .vfu_op_valid_i    (vfu_op_valid_i    ),
    .vfu_op_i          (vfu_op_i          ),
    .slide_cmd_pop_i   (slide_cmd_pop_i   ),
    .alu_red_complete_i(alu_red_complete_i),
    .fpu_red_complete_i(fpu_red_complete_i),
    .owner_o           (owner             )
  );

  // Steering of the shared bus
  bus_steer #(
    .elen_width(elen_width)
  ) i_bus_steer (
    .owner_i                (owner                  ),
    .opq_data_i             (opq_data_i             ),
    .opq_valid_i            (opq_valid_i            ),
    .opq_ready_o            (opq_ready_o            ),
    .alu_red_data_i         (alu_red_data_i         ),
    .alu_red_valid_i        (alu_red_valid_i        ),
    .alu_red_gnt_o          (alu_red_gnt_o          ),
    .fpu_red_data_i         (fpu_red_data_i         ),
    .fpu_red_valid_i        (fpu_red_valid_i        ),
    .fpu_red_gnt_o          (fpu_red_gnt_o          ),
    .shared_operand_o       (shared_operand_o       ),
    .sldu_operand_valid_o   (sldu_operand_valid_o   ),
    .sldu_operand_ready_i   (sldu_operand_ready_i   ),
    .addrgen_operand_valid_o(addrgen_operand_valid_o),
    .addrgen_operand_ready_i(addrgen_operand_ready_i),
    .sldu_red_valid_i       (sldu_red_valid_i       ),
    .alu_red_in_valid_o     (alu_red_in_valid_o     ),
    .fpu_red_in_valid_o     (fpu_red_in_valid_o     ),
    .alu_red_in_ready_i     (alu_red_in_ready_i     ),
    .fpu_red_in_ready_i     (fpu_red_in_ready_i     ),
    .sldu_result_gnt_opq_i  (sldu_result_gnt_opq_i  ),
    .sldu_result_gnt_o      (sldu_result_gnt_o      )
  );

  // Cuts the mask ready path
  mask_spill_register #(
    .elen_width(elen_width)
  ) i_mask_spill_register (
    .clk_i       (clk_i       ),
    .arst_n_i    (arst_n_i    ),
    .mask_i      (mask_i      ),
    .mask_valid_i(mask_valid_i),
    .mask_ready_o(mask_ready_o),
    .mask_o      (mask_o      ),
    .mask_valid_o(mask_valid_o),
    .mask_ready_i(mask_ready_i)
  );

endmodule

// File: rtl/mask_spill_register.sv
`timescale 1ns/1ns

module mask_spill_register #(
  parameter int unsigned elen_width = lane_bus_pkg::default_elen_width
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic [elen_width/8-1:0] mask_i,
  input  logic                    mask_valid_i,
  output logic                    mask_ready_o,
  output logic [elen_width/8-1:0] mask_o,
  output logic                    mask_valid_o,
  input  logic                    mask_ready_i
);

  localparam int unsigned mask_width = elen_width / 8;

  logic                  main_full_q;
  logic                  spill_full_q;
  logic [mask_width-1:0] main_data_q;
  logic [mask_width-1:0] spill_data_q;
  logic                  main_fill;
  logic                  main_drain;
  logic                  spill_fill;
  logic                  spill_drain;

  // Main slot takes new words
  assign main_fill  = mask_valid_i & mask_ready_o;
  // Main slot empties whenever the spill slot is free
  assign main_drain = main_full_q & ~spill_full_q;

  // Stalled output moves the main word into the spill slot
  assign spill_fill  = main_drain & ~mask_ready_i;
  assign spill_drain = spill_full_q & mask_ready_i;

  ////////////////////////////////////////
  // Slot state
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      main_full_q  <= 1'b0;
      spill_full_q <= 1'b0;
    end else begin
      if (main_fill) begin
        main_full_q <= 1'b1;
      end else if (main_drain) begin
        main_full_q <= 1'b0;
      end
      if (spill_fill) begin
        spill_full_q <= 1'b1;
      end else if (spill_drain) begin
        spill_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_fill) begin
      main_data_q <= mask_i;
    end
    if (spill_fill) begin
      spill_data_q <= main_data_q;
    end
  end

  // Ready depends on flops only
  assign mask_ready_o = ~(main_full_q & spill_full_q);

  // The spill slot always holds the older word
  assign mask_valid_o = main_full_q | spill_full_q;
  assign mask_o       = spill_full_q ? spill_data_q : main_data_q;

endmodule

// File: rtl/bus_steer.sv
`timescale 1ns/1ns

module bus_steer #(
  parameter int unsigned elen_width = lane_bus_pkg::default_elen_width
) (
  input  lane_bus_pkg::bus_owner_e owner_i,
  // Stream sources
  input  logic [elen_width-1:0]    opq_data_i,
  input  logic                     opq_valid_i,
  output logic                     opq_ready_o,
  input  logic [elen_width-1:0]    alu_red_data_i,
  input  logic                     alu_red_valid_i,
  output logic                     alu_red_gnt_o,
  input  logic [elen_width-1:0]    fpu_red_data_i,
  input  logic                     fpu_red_valid_i,
  output logic                     fpu_red_gnt_o,
  // Shared bus
  output logic [elen_width-1:0]    shared_operand_o,
  output logic                     sldu_operand_valid_o,
  input  logic                     sldu_operand_ready_i,
  output logic                     addrgen_operand_valid_o,
  input  logic                     addrgen_operand_ready_i,
  // Reduction return path
  input  logic                     sldu_red_valid_i,
  output logic                     alu_red_in_valid_o,
  output logic                     fpu_red_in_valid_o,
  input  logic                     alu_red_in_ready_i,
  input  logic                     fpu_red_in_ready_i,
  input  logic                     sldu_result_gnt_opq_i,
  output logic                     sldu_result_gnt_o
);

  import lane_bus_pkg::*;

  // Source choice on the shared bus
  localparam logic [1:0] src_opq = 2'd0;
  localparam logic [1:0] src_alu = 2'd1;
  localparam logic [1:0] src_fpu = 2'd2;

  logic [1:0] src_sel;

  always_comb begin
    unique case (owner_i)
      owner_alu_red: src_sel = src_alu;
      owner_fpu_red: src_sel = src_fpu;
      default:       src_sel = src_opq;
    endcase
  end

  ////////////////////////////////////////
  // Forward stream mux
  ////////////////////////////////////////

  always_comb begin
    shared_operand_o        = opq_data_i;
    sldu_operand_valid_o    = 1'b0;
    addrgen_operand_valid_o = 1'b0;
    opq_ready_o             = 1'b0;
    alu_red_gnt_o           = 1'b0;
    fpu_red_gnt_o           = 1'b0;

    case (src_sel)
      src_alu: begin
        shared_operand_o     = alu_red_data_i;
        sldu_operand_valid_o = alu_red_valid_i;
        alu_red_gnt_o        = sldu_operand_ready_i;
      end
      src_fpu: begin
        shared_operand_o     = fpu_red_data_i;
        sldu_operand_valid_o = fpu_red_valid_i;
        fpu_red_gnt_o        = sldu_operand_ready_i;
      end
      default: begin
        // Operand queue goes to whichever consumer owns the bus
        if (owner_i == owner_addrgen) begin
          addrgen_operand_valid_o = opq_valid_i;
          opq_ready_o             = addrgen_operand_ready_i;
        end else begin
          sldu_operand_valid_o = opq_valid_i;
          opq_ready_o          = sldu_operand_ready_i;
        end
      end
    endcase
  end

  // Reduction results return from the slide unit
  assign alu_red_in_valid_o = sldu_red_valid_i & (owner_i == owner_alu_red);
  assign fpu_red_in_valid_o = sldu_red_valid_i & (owner_i == owner_fpu_red);
  assign sldu_result_gnt_o  = (src_sel == src_alu) ? alu_red_in_ready_i :
                              (src_sel == src_fpu) ? fpu_red_in_ready_i :
                                                     sldu_result_gnt_opq_i;

endmodule

// File: rtl/bus_order_ctrl.sv
`timescale 1ns/1ns

module bus_order_ctrl #(
  parameter int unsigned order_depth = lane_bus_pkg::default_order_depth
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     flush_i,
  input  logic                     vfu_op_valid_i,
  input  vinsn_pkg::vop_e          vfu_op_i,
  input  logic                     slide_cmd_pop_i,
  input  logic                     alu_red_complete_i,
  input  logic                     fpu_red_complete_i,
  output lane_bus_pkg::bus_owner_e owner_o
);

  import vinsn_pkg::*;
  import lane_bus_pkg::*;

  localparam int unsigned ptr_width = (order_depth > 1) ? $clog2(order_depth) : 1;
  localparam int unsigned cnt_width = $clog2(order_depth + 1);

  logic                 op_valid_q;
  vop_e                 op_q;
  logic                 push;
  logic                 pop;
  bus_owner_e           push_owner;
  bus_owner_e           head_owner;
  bus_owner_e           record [order_depth];
  logic [ptr_width-1:0] rd_ptr_q;
  logic [ptr_width-1:0] wr_ptr_q;
  logic [cnt_width-1:0] count_q;
  logic                 empty;
  logic                 full;

  // Issue stage register, breaks the path from the sequencer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      op_valid_q <= 1'b0;
    end else begin
      op_valid_q <= vfu_op_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    op_q <= vfu_op_i;
  end

  assign empty      = (count_q == '0);
  assign full       = (count_q == cnt_width'(order_depth));
  assign head_owner = record[rd_ptr_q];
  assign owner_o    = empty ? owner_slide : head_owner;

  ////////////////////////////////////////
  // Classify and pop
  ////////////////////////////////////////

  always_comb begin
    push       = 1'b0;
    push_owner = owner_slide;
    pop        = 1'b0;

    if (op_valid_q) begin
      case (op_q) inside
        vop_vslideup, vop_vslidedown: begin
          push_owner = owner_slide;
          push       = 1'b1;
        end
        vop_vlxe, vop_vsxe: begin
          push_owner = owner_addrgen;
          push       = 1'b1;
        end
        [alu_red_first:alu_red_last]: begin
          push_owner = owner_alu_red;
          push       = 1'b1;
        end
        [fpu_red_first:fpu_red_last]: begin
          push_owner = owner_fpu_red;
          push       = 1'b1;
        end
        default: ;
      endcase
    end

    // Retire the head on its own completion strobe
    if (!empty) begin
      unique case (head_owner)
        owner_slide, owner_addrgen: pop = slide_cmd_pop_i;
        owner_alu_red:              pop = alu_red_complete_i;
        owner_fpu_red:              pop = fpu_red_complete_i;
      endcase
    end

    // Full record drops the push; flush discards it
    if (full || flush_i) begin
      push = 1'b0;
    end
  end

  ////////////////////////////////////////
  // Ordered owner record
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_width'(order_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_width'(order_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      record[wr_ptr_q] <= push_owner;
    end
  end

endmodule

// File: rtl/lane_bus_pkg.sv
package lane_bus_pkg;

  ////////////////////////////////////////
  // Shared operand bus owners
  ////////////////////////////////////////

  // Unit that currently owns the slide/addrgen operand bus
  typedef enum logic [1:0] {
    owner_slide   = 2'd0,
    owner_addrgen = 2'd1,
    owner_alu_red = 2'd2,
    owner_fpu_red = 2'd3
  } bus_owner_e;

  ////////////////////////////////////////
  // Default sizes
  ////////////////////////////////////////

  // Width of one element word on the bus
  localparam int unsigned default_elen_width = 64;

  // Operations in flight, one record entry each
  localparam int unsigned default_order_depth = 8;

endpackage

// File: rtl/vinsn_pkg.sv
package vinsn_pkg;

  // Reduced operation code
  // Only the codes the bus arbiter decodes are listed, plus a few plain ones
  typedef enum logic [5:0] {
    vop_vadd,
    vop_vsub,
    vop_vand,
    vop_vor,
    vop_vxor,
    vop_vmul,
    vop_vfadd,
    vop_vfmul,
    vop_vle,
    vop_vse,
    vop_vslideup,
    vop_vslidedown,
    vop_vlxe,
    vop_vsxe,
    // Integer reductions, contiguous range
    vop_vredsum,
    vop_vredand,
    vop_vredor,
    vop_vredxor,
    vop_vredminu,
    vop_vredmin,
    vop_vredmaxu,
    vop_vredmax,
    vop_vwredsumu,
    vop_vwredsum,
    // FP reductions, contiguous range
    vop_vfredusum,
    vop_vfredosum,
    vop_vfredmin,
    vop_vfredmax,
    vop_vfwredusum,
    vop_vfwredosum
  } vop_e;

  // Range bounds of the reduction codes
  localparam vop_e alu_red_first = vop_vredsum;
  localparam vop_e alu_red_last  = vop_vwredsum;
  localparam vop_e fpu_red_first = vop_vfredusum;
  localparam vop_e fpu_red_last  = vop_vfwredosum;

endpackage
